/* build.f */
+incdir+.
mod_pkg.sv
mod_wb_regs.sv
mod_timer.sv
mod_swapchain.sv
mod_buffer.sv
mod_top.sv
tb_mod_top.sv

/* mod_buffer.sv */
`default_nettype none

`include "mod_macros.svh"

module mod_buffer import mod_pkg::*; (
  input  wire logic                  CLK,
  input  mod_wr_t                    wr,
  input  wire logic                  wr_en,
  input  wire logic                  segment,
  input  wire logic [`MOD_IDX_W-1:0] idx,
  input  wire logic                  stop,
  output mod_out_t                   out
);

  localparam int ENTRIES = 2 * `MOD_DEPTH;

  // segment is the top address bit
  logic [`MOD_DATA_W-1:0] mem [ENTRIES];
  logic [`MOD_IDX_W:0]    wr_addr;
  logic [`MOD_IDX_W:0]    rd_addr;

  assign wr_addr = {wr.segment, wr.addr};
  assign rd_addr = {segment, idx};

  always_ff @(posedge CLK) begin
    if (wr_en) mem[wr_addr] <= wr.sample;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // registered read, status delayed to match the sample

  always_ff @(posedge CLK) begin
    out.sample  <= mem[rd_addr];
    out.segment <= segment;
    out.stop    <= stop;
  end

endmodule

`default_nettype wire

/* mod_macros.svh */
`ifndef MOD_MACROS_SVH
`define MOD_MACROS_SVH

// sample memory geometry
`define MOD_IDX_W  10
`define MOD_DEPTH  1024
`define MOD_DATA_W 8

// wishbone port widths
`define WB_ADR_W 12
`define WB_DAT_W 32

// register word addresses, taken from adr[2:0]
`define REG_CYCLE_0    3'd0
`define REG_FREQ_DIV_0 3'd1
`define REG_CYCLE_1    3'd2
`define REG_FREQ_DIV_1 3'd3
`define REG_REP        3'd4
`define REG_CTRL       3'd5

`endif

/* mod_pkg.sv */
`default_nettype none

`include "mod_macros.svh"

package mod_pkg;

  // everything the host programs through the register map
  typedef struct packed {
    logic [`WB_DAT_W-1:0] cycle_0;     // last index of segment 0
    logic [`WB_DAT_W-1:0] freq_div_0;  // clocks per index step, never 0
    logic [`WB_DAT_W-1:0] cycle_1;
    logic [`WB_DAT_W-1:0] freq_div_1;
    logic [`WB_DAT_W-1:0] rep;         // all ones plays forever
    logic                 req_segment;
  } mod_settings_t;

  // free running indices from the timer
  typedef struct packed {
    logic [`MOD_IDX_W-1:0] idx_0;
    logic [`MOD_IDX_W-1:0] idx_1;
    logic                  wrap_0;  // high in the first cycle of idx_0 == 0
    logic                  wrap_1;
  } mod_cnt_t;

  // one sample write into the buffer
  typedef struct packed {
    logic                   segment;
    logic [`MOD_IDX_W-1:0]  addr;
    logic [`MOD_DATA_W-1:0] sample;
  } mod_wr_t;

  // what leaves the sequencer each cycle
  typedef struct packed {
    logic [`MOD_DATA_W-1:0] sample;
    logic                   segment;
    logic                   stop;
  } mod_out_t;

endpackage

`default_nettype wire

/* mod_swapchain.sv */
`default_nettype none

`include "mod_macros.svh"

module mod_swapchain import mod_pkg::*; (
  input  wire logic                  CLK,
  input  wire logic                  rst,
  input  wire logic                  update,
  input  mod_settings_t              settings,
  input  mod_cnt_t                   cnt,
  output logic                       segment,
  output logic      [`MOD_IDX_W-1:0] idx,
  output logic                       stop
);

  logic                  pending;   // a swap waits here for the next period start
  logic                  req_seg;
  logic [`WB_DAT_W-1:0]  rep_lim;
  logic [`WB_DAT_W-1:0]  rep_cnt;   // periods completed since the count started

  logic                  seg_n;
  logic                  pend_n;
  logic                  req_n;
  logic [`WB_DAT_W-1:0]  lim_n;
  logic [`WB_DAT_W-1:0]  cnt_n;
  logic                  stop_n;
  logic [`MOD_IDX_W-1:0] idx_n;
  logic                  act_wrap;
  logic                  req_wrap;

  assign act_wrap = segment ? cnt.wrap_1 : cnt.wrap_0;
  assign req_wrap = req_seg ? cnt.wrap_1 : cnt.wrap_0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next state

  always_comb begin
    seg_n  = segment;
    pend_n = pending;
    req_n  = req_seg;
    lim_n  = rep_lim;
    cnt_n  = rep_cnt;
    stop_n = stop;

    if (update) begin
      if (settings.req_segment == segment) begin
        lim_n  = settings.rep;
        pend_n = 1'b0; // same segment just restarts the repeat count
        cnt_n  = '0;
        stop_n = 1'b0;
      end else begin
        pend_n = 1'b1;
        req_n  = settings.req_segment;
      end
    end else if (pending && req_wrap) begin
      seg_n  = req_seg;
      pend_n = 1'b0;
      lim_n  = settings.rep;
      cnt_n  = '0;
      stop_n = 1'b0;
    end else if (act_wrap && !stop && rep_lim != '1) begin
      if (rep_cnt == rep_lim) begin
        stop_n = 1'b1;
      end else begin
        cnt_n = rep_cnt + 1'b1;
      end
    end

    // Once stopped the output parks on the last entry of the segment
    if (stop_n) begin
      idx_n = seg_n ? settings.cycle_1[`MOD_IDX_W-1:0] : settings.cycle_0[`MOD_IDX_W-1:0];
    end else begin
      idx_n = seg_n ? cnt.idx_1 : cnt.idx_0;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      segment <= 1'b0;
      pending <= 1'b0;
      req_seg <= 1'b0;
      rep_lim <= '1;   // play forever until the host issues an update
      rep_cnt <= '0;
      stop    <= 1'b0;
      idx     <= '0;
    end else begin
      segment <= seg_n;
      pending <= pend_n;
      req_seg <= req_n;
      rep_lim <= lim_n;
      rep_cnt <= cnt_n;
      stop    <= stop_n;
      idx     <= idx_n;
    end
  end

  // a swap must land right after the timer starts a period of the new segment
  a_swap_on_wrap: assert property (@(posedge CLK) disable iff (rst)
    !$stable(segment) |-> (segment ? $past(cnt.wrap_1) : $past(cnt.wrap_0)));

endmodule

`default_nettype wire

/* mod_timer.sv */
`default_nettype none

`include "mod_macros.svh"

module mod_timer import mod_pkg::*; (
  input  wire logic    CLK,
  input  wire logic    rst,
  input  mod_settings_t settings,
  input  wire logic    restart_0,
  input  wire logic    restart_1,
  output mod_cnt_t     cnt
);

  // both segments run the same counter pair, indexed 0 and 1
  logic [1:0][`WB_DAT_W-1:0]  div;
  logic [1:0][`MOD_IDX_W-1:0] last;
  logic [1:0]                 restart;
  logic [1:0][`WB_DAT_W-1:0]  presc;
  logic [1:0][`MOD_IDX_W-1:0] idx;
  logic [1:0]                 wrap;

  always_comb begin
    div[0]     = settings.freq_div_0;
    div[1]     = settings.freq_div_1;
    last[0]    = settings.cycle_0[`MOD_IDX_W-1:0];
    last[1]    = settings.cycle_1[`MOD_IDX_W-1:0];
    restart[0] = restart_0;
    restart[1] = restart_1;
  end

  // the index steps on the same edge that the prescaler wraps
  always_ff @(posedge CLK) begin
    if (rst) begin
      presc <= '0;
      idx   <= '0;
      wrap  <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        wrap[i] <= 1'b0;
        if (restart[i]) begin
          presc[i] <= '0;
          idx[i]   <= '0;
        end else if (presc[i] >= div[i] - 1) begin
          presc[i] <= '0;
          if (idx[i] >= last[i]) begin
            idx[i]  <= '0;
            wrap[i] <= 1'b1; // start of a new period
          end else begin
            idx[i] <= idx[i] + 1'b1;
          end
        end else begin
          presc[i] <= presc[i] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    cnt.idx_0  = idx[0];
    cnt.idx_1  = idx[1];
    cnt.wrap_0 = wrap[0];
    cnt.wrap_1 = wrap[1];
  end

  // a new cycle value lands together with restart, so that cycle is exempt
  for (genvar g = 0; g < 2; g++) begin : g_chk
    a_idx_range: assert property (@(posedge CLK) disable iff (rst)
      !restart[g] |-> idx[g] <= last[g]);
  end

endmodule

`default_nettype wire

/* mod_top.sv */
`default_nettype none

`include "mod_macros.svh"

module mod_top import mod_pkg::*; (
  input  wire logic                 CLK,
  input  wire logic                 rst,
  input  wire logic                 cyc,
  input  wire logic                 stb,
  input  wire logic                 we,
  input  wire logic [`WB_ADR_W-1:0] adr,
  input  wire logic [`WB_DAT_W-1:0] dat_w,
  output logic      [`WB_DAT_W-1:0] dat_r,
  output logic                      ack,
  output mod_out_t                  out
);

  mod_settings_t         settings;
  mod_cnt_t              cnt;
  mod_wr_t               wr;
  logic                  wr_en;
  logic                  restart_0;
  logic                  restart_1;
  logic                  update;
  logic                  segment;
  logic [`MOD_IDX_W-1:0] idx;
  logic                  stop;

  // host side
  mod_wb_regs u_wb_regs (
    .CLK       (CLK),
    .rst       (rst),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_w     (dat_w),
    .dat_r     (dat_r),
    .ack       (ack),
    .settings  (settings),
    .restart_0 (restart_0),
    .restart_1 (restart_1),
    .update    (update),
    .wr        (wr),
    .wr_en     (wr_en)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sample pipeline: timer, segment select, memory

  mod_timer u_timer (
    .CLK       (CLK),
    .rst       (rst),
    .settings  (settings),
    .restart_0 (restart_0),
    .restart_1 (restart_1),
    .cnt       (cnt)
  );

  mod_swapchain u_swapchain (
    .CLK      (CLK),
    .rst      (rst),
    .update   (update),
    .settings (settings),
    .cnt      (cnt),
    .segment  (segment),
    .idx      (idx),
    .stop     (stop)
  );

  mod_buffer u_buffer (
    .CLK     (CLK),
    .wr      (wr),
    .wr_en   (wr_en),
    .segment (segment),
    .idx     (idx),
    .stop    (stop),
    .out     (out)
  );

endmodule

`default_nettype wire

/* mod_wb_regs.sv */
`default_nettype none

`include "mod_macros.svh"

module mod_wb_regs import mod_pkg::*; (
  input  wire logic                 CLK,
  input  wire logic                 rst,
  input  wire logic                 cyc,
  input  wire logic                 stb,
  input  wire logic                 we,
  input  wire logic [`WB_ADR_W-1:0] adr,
  input  wire logic [`WB_DAT_W-1:0] dat_w,
  output logic      [`WB_DAT_W-1:0] dat_r,
  output logic                      ack,
  output mod_settings_t             settings,
  output logic                      restart_0,
  output logic                      restart_1,
  output logic                      update,
  output mod_wr_t                   wr,
  output logic                      wr_en
);

  logic                 access;
  logic                 buf_sel;
  logic [2:0]           reg_adr;
  logic [`WB_DAT_W-1:0] rd_data;

  // ack is high for the one cycle after the request, so it also blocks a repeat
  assign access  = cyc && stb && !ack;
  assign buf_sel = adr[`WB_ADR_W-1];
  assign reg_adr = adr[2:0];

  always_comb begin
    rd_data = '0;
    if (!buf_sel) begin
      case (reg_adr)
        `REG_CYCLE_0:    rd_data = settings.cycle_0;
        `REG_FREQ_DIV_0: rd_data = settings.freq_div_0;
        `REG_CYCLE_1:    rd_data = settings.cycle_1;
        `REG_FREQ_DIV_1: rd_data = settings.freq_div_1;
        `REG_REP:        rd_data = settings.rep;
        `REG_CTRL:       rd_data[0] = settings.req_segment;
        default:         rd_data = '0;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus handshake and strobes

  always_ff @(posedge CLK) begin
    if (rst) begin
      ack       <= 1'b0;
      restart_0 <= 1'b0;
      restart_1 <= 1'b0;
      update    <= 1'b0;
      wr_en     <= 1'b0;
    end else begin
      ack       <= access;
      restart_0 <= access && we && !buf_sel &&
                   (reg_adr == `REG_CYCLE_0 || reg_adr == `REG_FREQ_DIV_0);
      restart_1 <= access && we && !buf_sel &&
                   (reg_adr == `REG_CYCLE_1 || reg_adr == `REG_FREQ_DIV_1);
      update    <= access && we && !buf_sel && (reg_adr == `REG_CTRL);
      wr_en     <= access && we && buf_sel;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // settings registers

  always_ff @(posedge CLK) begin
    if (rst) begin
      settings            <= '0;
      settings.freq_div_0 <= `WB_DAT_W'(1);
      settings.freq_div_1 <= `WB_DAT_W'(1);
    end else if (access && we && !buf_sel) begin
      case (reg_adr)
        `REG_CYCLE_0:    settings.cycle_0     <= dat_w;
        `REG_FREQ_DIV_0: settings.freq_div_0  <= dat_w;
        `REG_CYCLE_1:    settings.cycle_1     <= dat_w;
        `REG_FREQ_DIV_1: settings.freq_div_1  <= dat_w;
        `REG_REP:        settings.rep         <= dat_w;
        `REG_CTRL:       settings.req_segment <= dat_w[0];
        default:         ;
      endcase
    end
  end

  // read data and the buffer write payload
  always_ff @(posedge CLK) begin
    if (access && !we) dat_r <= rd_data; // buffer addresses read back as zero
    if (access && we && buf_sel) begin
      wr.segment <= adr[`MOD_IDX_W];
      wr.addr    <= adr[`MOD_IDX_W-1:0];
      wr.sample  <= dat_w[`MOD_DATA_W-1:0];
    end
  end

  a_ack_single: assert property (@(posedge CLK) disable iff (rst) ack |=> !ack);

  a_div_nonzero: assert property (@(posedge CLK) disable iff (rst)
    settings.freq_div_0 != '0 && settings.freq_div_1 != '0);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f build.f \
  --top-module tb_mod_top --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'TESTBENCH PASSED'; then
  exit 0
fi
exit 1

/* tb_mod_top.sv */
`default_nettype none

`include "mod_macros.svh"

module tb_mod_top import mod_pkg::*; ();

  localparam int CYCLE_0 = 19;
  localparam int DIV_0   = 10;
  localparam int CYCLE_1 = 9;
  localparam int DIV_1   = 30;
  localparam int NSTEPS  = 3;

  typedef logic [`MOD_IDX_W:0] maddr_t; // {segment, entry}

  logic                 CLK;
  logic                 rst;
  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic [`WB_ADR_W-1:0] adr;
  logic [`WB_DAT_W-1:0] dat_w;
  logic [`WB_DAT_W-1:0] dat_r;
  logic                 ack;
  mod_out_t             out;

  logic [`MOD_DATA_W-1:0] model [2*`MOD_DEPTH];
  integer seed = 32'hf2f8_8039;
  int     errors = 0;
  int     tests = 0;
  int     failed_tests = 0;
  int     test_err0;
  string  cur_test;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // the step table holds the requested segment, the repeat count and the periods to observe
  string       step_name    [NSTEPS] = '{"swap_to_1_rep_1", "swap_to_0_rep_2", "forever_on_1"};
  logic        step_seg     [NSTEPS] = '{1'b1, 1'b0, 1'b1};
  logic [31:0] step_rep     [NSTEPS] = '{32'd1, 32'd2, 32'hffff_ffff};
  int          step_periods [NSTEPS] = '{2, 3, 8};

  // register map contents in address order with CTRL last
  logic [31:0] reg_val [6] = '{32'(CYCLE_0), 32'(DIV_0), 32'(CYCLE_1), 32'(DIV_1),
                               32'hffff_ffff, 32'd0};

  mod_top dut0 (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  function automatic int seg_last(input logic seg);
    return seg ? CYCLE_1 : CYCLE_0;
  endfunction

  function automatic int seg_div(input logic seg);
    return seg ? DIV_1 : DIV_0;
  endfunction

  function automatic logic [`MOD_DATA_W-1:0] model_sample(input logic seg, input int entry);
    maddr_t a;
    a = {seg, entry[`MOD_IDX_W-1:0]};
    return model[a];
  endfunction

  task automatic compare(input string tag, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch %s (%s): expected %0h, actual %0h", cur_test, tag, exp, act);
      errors++;
    end
  endtask

  task automatic open_test(input string name);
    cur_test  = name;
    test_err0 = errors;
    tests++;
  endtask

  task automatic close_test();
    if (errors == test_err0) begin
      $display("test %s ok", cur_test);
    end else begin
      failed_tests++;
      $display("test %s failed with %0d errors", cur_test, errors - test_err0);
    end
  endtask

  // one classic cycle; ack must come on the first edge and last one cycle
  task automatic bus_access(input logic write, input logic [`WB_ADR_W-1:0] a,
                            input logic [31:0] d, output logic [31:0] q);
    int n;
    @(negedge CLK);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = a;
    dat_w = d;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (!ack && n < 16);
    q   = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    if (!ack) begin
      $display("%s: no ack on bus access to address %h", cur_test, a);
      errors++;
    end else begin
      compare("ack latency", 32'd1, 32'(n));
      @(negedge CLK);
      compare("ack width", 32'd0, 32'(ack));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request a segment and follow the output against the model

  task automatic play_step(input logic [1:0] s);
    logic        seg;
    logic        stops;
    logic [31:0] q;
    int          last;
    int          div;
    int          n;
    int          h;
    int          exp_idx;
    int          periods;
    bit          done;
    seg   = step_seg[s];
    stops = (step_rep[s] != 32'hffff_ffff);
    last  = seg_last(seg);
    div   = seg_div(seg);
    open_test(step_name[s]);
    bus_access(1'b1, {9'd0, `REG_REP}, step_rep[s], q);
    bus_access(1'b1, {9'd0, `REG_CTRL}, 32'(seg), q);
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (out.segment != seg && n < 2 * (last + 1) * div + 8);
    if (out.segment != seg) begin
      $display("%s: output never switched to segment %0d", cur_test, seg);
      errors++;
    end else begin
      compare("first sample", 32'(model_sample(seg, 0)), 32'(out.sample));
      compare("stop at swap", 32'd0, 32'(out.stop));
      h       = 1; // first cycle of entry 0 already seen
      exp_idx = 0;
      periods = 0;
      done    = 1'b0;
      while (!done) begin
        @(negedge CLK);
        if (h == div) begin
          h = 1;
          if (exp_idx == last) begin
            exp_idx = 0;
            periods++;
          end else begin
            exp_idx++;
          end
        end else begin
          h++;
        end
        if (out.stop) begin
          compare("stop expected", 32'(stops), 32'd1);
          compare("periods at stop", 32'(step_periods[s]), 32'(periods));
          compare("sample at stop", 32'(model_sample(seg, last)), 32'(out.sample));
          done = 1'b1;
        end else begin
          compare("sample", 32'(model_sample(seg, exp_idx)), 32'(out.sample));
          compare("segment", 32'(seg), 32'(out.segment));
          if (stops && periods > step_periods[s]) begin
            $display("%s: stop did not rise after %0d periods", cur_test, periods);
            errors++;
            done = 1'b1;
          end else if (!stops && periods == step_periods[s]) begin
            done = 1'b1;
          end
        end
      end
      if (out.stop) begin
        repeat (2 * div) begin
          @(negedge CLK);
          compare("stopped sample", 32'(model_sample(seg, last)), 32'(out.sample));
          compare("stop held", 32'd1, 32'(out.stop));
        end
      end
    end
    bus_access(1'b0, {9'd0, `REG_CTRL}, 32'd0, q);
    compare("ctrl readback", 32'(seg), q);
    close_test();
  endtask

  initial begin
    logic [31:0] q;
    logic [31:0] r;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    rst   = 1'b1;
    for (int i = 0; i < 2 * `MOD_DEPTH; i++) begin
      r = $random(seed);
      model[maddr_t'(i)] = r[`MOD_DATA_W-1:0];
    end
    repeat (16) @(negedge CLK);
    rst = 1'b0;

    open_test("reset");
    @(negedge CLK);
    compare("ack", 32'd0, 32'(ack));
    compare("stop", 32'd0, 32'(out.stop));
    compare("segment", 32'd0, 32'(out.segment));
    close_test();

    open_test("reg_readback");
    for (int i = 0; i < 6; i++) bus_access(1'b1, 12'(i), reg_val[3'(i)], q);
    for (int i = 5; i >= 0; i--) begin
      bus_access(1'b0, 12'(i), 32'd0, q);
      compare($sformatf("reg %0d", i), reg_val[3'(i)], q);
    end
    close_test();

    open_test("buffer_fill");
    for (int i = 0; i < 2 * `MOD_DEPTH; i++) begin
      bus_access(1'b1, {1'b1, maddr_t'(i)}, 32'(model[maddr_t'(i)]), q);
    end
    bus_access(1'b0, {1'b1, 11'h005}, 32'd0, q);
    compare("buffer read", 32'd0, q);
    close_test();

    for (int i = 0; i < NSTEPS; i++) play_step(2'(i));

    $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // the limit in cycles covers reset, the bus traffic and every step's periods with margin
  initial begin
    int limit;
    limit = 16 + 4 * (2 * `MOD_DEPTH + 16);
    for (int s = 0; s < NSTEPS; s++) begin
      limit += (step_periods[2'(s)] + 3) * (seg_last(step_seg[2'(s)]) + 1)
               * seg_div(step_seg[2'(s)]) + 4 * seg_div(step_seg[2'(s)]);
    end
    repeat (2 * limit) @(posedge CLK);
    $display("watchdog: simulation did not finish within %0d cycles", 2 * limit);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire
